// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f \
    --top-module tb_cache_memctrl -o Vtb_cache_memctrl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_cache_memctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Finished with no errors$" "$LOG"; then
    exit 0
fi
exit 1

// ==== sources.f ====
src/memctrl_pkg.sv
src/cache_sram.sv
src/dir_ctrl.sv
src/data_ctrl.sv
src/tag_match.sv
src/victim_sel.sv
src/cache_memctrl.sv
test/cache_memctrl_sva.sv
test/tb_cache_memctrl.sv

// ==== src/cache_memctrl.sv ====
// Top level of the cache directory and data memory controller.
// Wires the two command generators, one directory and one data RAM per way,
// the tag matcher and the victim selector.
`timescale 1ns/1ns

module cache_memctrl #(
    parameter int  NUM_WAYS = memctrl_pkg::DEF_NUM_WAYS,
    parameter int  NUM_SETS = memctrl_pkg::DEF_NUM_SETS,
    parameter int  CL_WORDS = memctrl_pkg::DEF_CL_WORDS,
    localparam int SET_W    = $clog2(NUM_SETS),
    localparam int WIDX_W   = $clog2(CL_WORDS),
    localparam int ADDR_W   = $clog2(NUM_SETS * CL_WORDS)
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    output logic                    ready_o,

    input  logic                    dir_match_i,
    input  logic [SET_W-1:0]        dir_match_set_i,
    input  memctrl_pkg::tag_t       dir_match_tag_i,
    output logic [NUM_WAYS-1:0]     dir_hit_way_o,

    input  logic                    dir_refill_sel_victim_i,
    input  logic                    dir_refill_i,
    input  logic [SET_W-1:0]        dir_refill_set_i,
    input  memctrl_pkg::tag_t       dir_refill_tag_i,
    output logic [NUM_WAYS-1:0]     dir_victim_way_o,

    input  logic                    data_req_read_i,
    input  logic [SET_W-1:0]        data_req_read_set_i,
    input  logic [WIDX_W-1:0]       data_req_read_word_i,
    output memctrl_pkg::data_word_t read_data_o,

    input  logic                    data_req_write_i,
    input  logic                    data_req_write_enable_i,
    input  logic [SET_W-1:0]        data_req_write_set_i,
    input  logic [WIDX_W-1:0]       data_req_write_word_i,
    input  memctrl_pkg::data_word_t data_req_write_data_i,

    input  logic                    data_refill_i,
    input  logic [NUM_WAYS-1:0]     data_refill_way_i,
    input  logic [SET_W-1:0]        data_refill_set_i,
    input  logic [WIDX_W-1:0]       data_refill_word_i,
    input  memctrl_pkg::data_word_t data_refill_data_i
);

    memctrl_pkg::dir_cmd_t                  dir_cmd;
    memctrl_pkg::data_cmd_t                 data_cmd;
    memctrl_pkg::dir_entry_t [NUM_WAYS-1:0] dir_rentry;
    memctrl_pkg::data_word_t [NUM_WAYS-1:0] data_rword;

    dir_ctrl #(
        .NUM_WAYS                (NUM_WAYS),
        .NUM_SETS                (NUM_SETS)
    ) dir_ctrl_i (
        .clk_i                   (clk_i),
        .rst_ni                  (rst_ni),
        .dir_match_i             (dir_match_i),
        .dir_match_set_i         (dir_match_set_i),
        .dir_refill_sel_victim_i (dir_refill_sel_victim_i),
        .dir_refill_i            (dir_refill_i),
        .dir_refill_set_i        (dir_refill_set_i),
        .dir_refill_tag_i        (dir_refill_tag_i),
        .victim_way_i            (dir_victim_way_o),
        .ready_o                 (ready_o),
        .dir_cmd_o               (dir_cmd)
    );

    data_ctrl #(
        .NUM_WAYS                (NUM_WAYS),
        .NUM_SETS                (NUM_SETS),
        .CL_WORDS                (CL_WORDS)
    ) data_ctrl_i (
        .data_req_read_i         (data_req_read_i),
        .data_req_read_set_i     (data_req_read_set_i),
        .data_req_read_word_i    (data_req_read_word_i),
        .data_req_write_i        (data_req_write_i),
        .data_req_write_enable_i (data_req_write_enable_i),
        .data_req_write_set_i    (data_req_write_set_i),
        .data_req_write_word_i   (data_req_write_word_i),
        .data_req_write_data_i   (data_req_write_data_i),
        .data_refill_i           (data_refill_i),
        .data_refill_way_i       (data_refill_way_i),
        .data_refill_set_i       (data_refill_set_i),
        .data_refill_word_i      (data_refill_word_i),
        .data_refill_data_i      (data_refill_data_i),
        .hit_way_i               (dir_hit_way_o),
        .data_cmd_o              (data_cmd)
    );

    // One directory RAM and one data RAM per way
    for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
        cache_sram #(
            .payload_t (memctrl_pkg::dir_entry_t),
            .DEPTH     (NUM_SETS)
        ) dir_sram_i (
            .clk_i     (clk_i),
            .cs_i      (dir_cmd.cs[w]),
            .we_i      (dir_cmd.we[w]),
            .addr_i    (dir_cmd.set[SET_W-1:0]),
            .wdata_i   (dir_cmd.wentry),
            .rdata_o   (dir_rentry[w])
        );

        cache_sram #(
            .payload_t (memctrl_pkg::data_word_t),
            .DEPTH     (NUM_SETS * CL_WORDS)
        ) data_sram_i (
            .clk_i     (clk_i),
            .cs_i      (data_cmd.rd | data_cmd.we[w]),
            .we_i      (data_cmd.we[w]),
            .addr_i    (data_cmd.addr[ADDR_W-1:0]),
            .wdata_i   (data_cmd.wdata),
            .rdata_o   (data_rword[w])
        );
    end

    tag_match #(
        .NUM_WAYS        (NUM_WAYS)
    ) tag_match_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .dir_match_i     (dir_match_i),
        .dir_match_tag_i (dir_match_tag_i),
        .dir_rentry_i    (dir_rentry),
        .data_rword_i    (data_rword),
        .hit_way_o       (dir_hit_way_o),
        .read_data_o     (read_data_o)
    );

    victim_sel #(
        .NUM_WAYS        (NUM_WAYS)
    ) victim_sel_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .dir_refill_i    (dir_refill_i),
        .dir_rentry_i    (dir_rentry),
        .victim_way_o    (dir_victim_way_o)
    );

endmodule

// ==== src/cache_sram.sv ====
// Single-port synchronous RAM with a registered read port.
// Instantiated once per way for both directory entries and data words.
`timescale 1ns/1ns

module cache_sram #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 16
) (
    input  logic                     clk_i,
    input  logic                     cs_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  payload_t                 wdata_i,
    output payload_t                 rdata_o
);

    payload_t mem_q [DEPTH];
    payload_t rdata_q;

    // Read port only updates on a read access, it holds otherwise
    always_ff @(posedge clk_i) begin
        if (cs_i) begin
            if (we_i) begin
                mem_q[addr_i] <= wdata_i;
            end else begin
                rdata_q <= mem_q[addr_i];
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== src/data_ctrl.sv ====
// Data RAM command generator. Maps (set, word) to a RAM address and picks
// the way to write from the refill way or the last lookup hit.
`timescale 1ns/1ns

module data_ctrl #(
    parameter int  NUM_WAYS = memctrl_pkg::DEF_NUM_WAYS,
    parameter int  NUM_SETS = memctrl_pkg::DEF_NUM_SETS,
    parameter int  CL_WORDS = memctrl_pkg::DEF_CL_WORDS,
    localparam int SET_W    = $clog2(NUM_SETS),
    localparam int WIDX_W   = $clog2(CL_WORDS),
    localparam int ADDR_W   = $clog2(NUM_SETS * CL_WORDS)
) (
    input  logic                   data_req_read_i,
    input  logic [SET_W-1:0]       data_req_read_set_i,
    input  logic [WIDX_W-1:0]      data_req_read_word_i,

    input  logic                   data_req_write_i,
    input  logic                   data_req_write_enable_i,
    input  logic [SET_W-1:0]       data_req_write_set_i,
    input  logic [WIDX_W-1:0]      data_req_write_word_i,
    input  memctrl_pkg::data_word_t data_req_write_data_i,

    input  logic                   data_refill_i,
    input  logic [NUM_WAYS-1:0]    data_refill_way_i,
    input  logic [SET_W-1:0]       data_refill_set_i,
    input  logic [WIDX_W-1:0]      data_refill_word_i,
    input  memctrl_pkg::data_word_t data_refill_data_i,

    input  logic [NUM_WAYS-1:0]    hit_way_i,
    output memctrl_pkg::data_cmd_t data_cmd_o
);

    // Word offset inside the line stored at set * CL_WORDS
    function automatic logic [ADDR_W-1:0] line_addr(input logic [SET_W-1:0]  set,
                                                    input logic [WIDX_W-1:0] word);
        int unsigned idx;
        idx = int'(set) * CL_WORDS + int'(word);
        return idx[ADDR_W-1:0];
    endfunction

    always_comb begin
        data_cmd_o = '0;

        if (data_refill_i) begin
            data_cmd_o.we[NUM_WAYS-1:0] = data_refill_way_i;
            data_cmd_o.addr[ADDR_W-1:0] = line_addr(data_refill_set_i, data_refill_word_i);
            data_cmd_o.wdata            = data_refill_data_i;
        end else if (data_req_write_i) begin
            // Disabled writes still select the address but write nothing
            data_cmd_o.we[NUM_WAYS-1:0] = data_req_write_enable_i ? hit_way_i : '0;
            data_cmd_o.addr[ADDR_W-1:0] = line_addr(data_req_write_set_i, data_req_write_word_i);
            data_cmd_o.wdata            = data_req_write_data_i;
        end else if (data_req_read_i) begin
            data_cmd_o.rd               = 1'b1;
            data_cmd_o.addr[ADDR_W-1:0] = line_addr(data_req_read_set_i, data_req_read_word_i);
        end
    end

endmodule

// ==== src/dir_ctrl.sv ====
// Directory command generator. Clears every set after reset, then arbitrates
// lookups, victim reads and refill writes onto the directory RAMs.
`timescale 1ns/1ns

module dir_ctrl #(
    parameter int   NUM_WAYS = memctrl_pkg::DEF_NUM_WAYS,
    parameter int   NUM_SETS = memctrl_pkg::DEF_NUM_SETS,
    localparam int  SET_W    = $clog2(NUM_SETS)
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  logic                  dir_match_i,
    input  logic [SET_W-1:0]      dir_match_set_i,

    input  logic                  dir_refill_sel_victim_i,
    input  logic                  dir_refill_i,
    input  logic [SET_W-1:0]      dir_refill_set_i,
    input  memctrl_pkg::tag_t     dir_refill_tag_i,

    input  logic [NUM_WAYS-1:0]   victim_way_i,

    output logic                  ready_o,
    output memctrl_pkg::dir_cmd_t dir_cmd_o
);

    logic             init_done_q;
    logic [SET_W-1:0] init_set_q;

    // One set per cycle until the last one is cleared
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_done_q <= 1'b0;
            init_set_q  <= '0;
        end else if (!init_done_q) begin
            init_set_q <= init_set_q + 1'b1;
            if (init_set_q == SET_W'(NUM_SETS - 1)) begin
                init_done_q <= 1'b1;
            end
        end
    end

    assign ready_o = init_done_q;

    // Fixed priority: init, lookup, victim read, refill write
    always_comb begin
        dir_cmd_o = '0;

        if (!init_done_q) begin
            dir_cmd_o.cs[NUM_WAYS-1:0]  = '1;
            dir_cmd_o.we[NUM_WAYS-1:0]  = '1;
            dir_cmd_o.set[SET_W-1:0]    = init_set_q;
        end else if (dir_match_i) begin
            dir_cmd_o.cs[NUM_WAYS-1:0]  = '1;
            dir_cmd_o.set[SET_W-1:0]    = dir_match_set_i;
        end else if (dir_refill_sel_victim_i) begin
            dir_cmd_o.cs[NUM_WAYS-1:0]  = '1;
            dir_cmd_o.set[SET_W-1:0]    = dir_refill_set_i;
        end else if (dir_refill_i) begin
            // Only the victim way is touched
            dir_cmd_o.cs[NUM_WAYS-1:0]  = victim_way_i;
            dir_cmd_o.we[NUM_WAYS-1:0]  = victim_way_i;
            dir_cmd_o.set[SET_W-1:0]    = dir_refill_set_i;
            dir_cmd_o.wentry.valid      = 1'b1;
            dir_cmd_o.wentry.tag        = dir_refill_tag_i;
        end
    end

endmodule

// ==== src/memctrl_pkg.sv ====
// Shared widths, defaults and command types for the cache directory and data
// RAM controller. Referenced by scoped name from every RTL file.
package memctrl_pkg;

    // Payload widths
    localparam int TAG_WIDTH  = 8;
    localparam int WORD_WIDTH = 32;

    // Upper bounds used to size the command structs
    localparam int MAX_WAYS            = 8;
    localparam int MAX_SET_WIDTH       = 8;
    localparam int MAX_DATA_ADDR_WIDTH = 12;

    // Defaults for the top-level geometry
    localparam int DEF_NUM_WAYS = 4;
    localparam int DEF_NUM_SETS = 16;
    localparam int DEF_CL_WORDS = 4;

    typedef logic [TAG_WIDTH-1:0]  tag_t;
    typedef logic [WORD_WIDTH-1:0] data_word_t;

    // One directory entry per set and way
    typedef struct packed {
        logic valid;
        tag_t tag;
    } dir_entry_t;

    // Directory RAM command, only the low NUM_WAYS bits of cs/we are used
    typedef struct packed {
        logic [MAX_WAYS-1:0]      cs;
        logic [MAX_WAYS-1:0]      we;
        logic [MAX_SET_WIDTH-1:0] set;
        dir_entry_t               wentry;
    } dir_cmd_t;

    // Data RAM command, a read goes to every way
    typedef struct packed {
        logic                           rd;
        logic [MAX_WAYS-1:0]            we;
        logic [MAX_DATA_ADDR_WIDTH-1:0] addr;
        data_word_t                     wdata;
    } data_cmd_t;

endpackage

// ==== src/tag_match.sv ====
// Lookup tag comparison. Produces the one-hot hit way one cycle after a
// lookup, keeps it for later request writes, and selects the read word.
`timescale 1ns/1ns

module tag_match #(
    parameter int NUM_WAYS = memctrl_pkg::DEF_NUM_WAYS
) (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    input  logic                                   dir_match_i,
    input  memctrl_pkg::tag_t                      dir_match_tag_i,
    input  memctrl_pkg::dir_entry_t [NUM_WAYS-1:0] dir_rentry_i,
    input  memctrl_pkg::data_word_t [NUM_WAYS-1:0] data_rword_i,
    output logic [NUM_WAYS-1:0]                    hit_way_o,
    output memctrl_pkg::data_word_t                read_data_o
);

    memctrl_pkg::tag_t   tag_q;
    logic                match_q;
    logic [NUM_WAYS-1:0] hit_live;
    logic [NUM_WAYS-1:0] hit_q;

    // Tag lines up with the directory read one cycle later
    always_ff @(posedge clk_i) begin
        if (dir_match_i) begin
            tag_q <= dir_match_tag_i;
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_live[w] = dir_rentry_i[w].valid && (dir_rentry_i[w].tag == tag_q);
        end
    end

    // Last hit is kept since a victim read moves the directory read port
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            match_q <= 1'b0;
            hit_q   <= '0;
        end else begin
            match_q <= dir_match_i;
            if (match_q) begin
                hit_q <= hit_live;
            end
        end
    end

    assign hit_way_o = match_q ? hit_live : hit_q;

    // One-hot mux, zero on a miss
    always_comb begin
        read_data_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_way_o[w]) begin
                read_data_o = read_data_o | data_rword_i[w];
            end
        end
    end

endmodule

// ==== src/victim_sel.sv ====
// Replacement way choice: lowest invalid way of the set read from the
// directory, else a global round-robin pointer.
`timescale 1ns/1ns

module victim_sel #(
    parameter int  NUM_WAYS = memctrl_pkg::DEF_NUM_WAYS,
    localparam int PTR_W    = $clog2(NUM_WAYS)
) (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    input  logic                                   dir_refill_i,
    input  memctrl_pkg::dir_entry_t [NUM_WAYS-1:0] dir_rentry_i,
    output logic [NUM_WAYS-1:0]                    victim_way_o
);

    logic [PTR_W-1:0]    rr_q;
    logic [NUM_WAYS-1:0] valid_vec;
    logic [NUM_WAYS-1:0] first_invalid;
    logic [NUM_WAYS-1:0] rr_onehot;
    logic                all_valid;

    always_comb begin
        first_invalid = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            valid_vec[w] = dir_rentry_i[w].valid;
            if (!dir_rentry_i[w].valid) begin
                first_invalid    = '0;
                first_invalid[w] = 1'b1;
            end
        end
    end

    for (genvar g = 0; g < NUM_WAYS; g++) begin : gen_rr_dec
        assign rr_onehot[g] = (rr_q == PTR_W'(g));
    end

    assign all_valid    = &valid_vec;
    assign victim_way_o = all_valid ? rr_onehot : first_invalid;

    // Pointer only moves when a full set consumed it
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rr_q <= '0;
        end else if (dir_refill_i && all_valid) begin
            rr_q <= (rr_q == PTR_W'(NUM_WAYS - 1)) ? '0 : rr_q + 1'b1;
        end
    end

endmodule

// ==== test/cache_memctrl_sva.sv ====
// Assertions on strobe exclusivity and the ready signal.
// Bound into cache_memctrl by the testbench.
`timescale 1ns/1ns

module cache_memctrl_sva (
    input logic clk_i,
    input logic rst_ni,
    input logic ready_o,
    input logic dir_match_i,
    input logic dir_refill_sel_victim_i,
    input logic dir_refill_i,
    input logic data_req_read_i,
    input logic data_req_write_i,
    input logic data_refill_i
);

    a_one_dir_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({dir_match_i, dir_refill_sel_victim_i, dir_refill_i}))
        else $error("More than one directory strobe in a cycle");

    a_one_data_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({data_req_read_i, data_req_write_i, data_refill_i}))
        else $error("More than one data strobe in a cycle");

    // Once the directory is cleared it stays usable
    a_ready_stays: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ready_o |=> ready_o)
        else $error("ready_o fell after initialization");

    a_idle_before_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !ready_o |-> !(dir_match_i | dir_refill_sel_victim_i | dir_refill_i |
                       data_req_read_i | data_req_write_i | data_refill_i))
        else $error("Strobe issued while ready_o was low");

endmodule

// ==== test/tb_cache_memctrl.sv ====
// Testbench for the cache directory and data memory controller.
// Random refills, lookups and request writes are checked against a model.
`timescale 1ns/1ns

module tb_cache_memctrl;

    localparam int NUM_WAYS   = memctrl_pkg::DEF_NUM_WAYS;
    localparam int NUM_SETS   = memctrl_pkg::DEF_NUM_SETS;
    localparam int CL_WORDS   = memctrl_pkg::DEF_CL_WORDS;
    localparam int SET_W      = $clog2(NUM_SETS);
    localparam int WIDX_W     = $clog2(CL_WORDS);
    // Few sets in use so that sets fill up and the round-robin pointer moves
    localparam int SETS_USED  = 4;
    localparam int NUM_OPS    = 48;
    localparam int OP_CYCLES  = 12 + CL_WORDS;
    localparam int TIMEOUT_NS = 2 * 4 * (3 + 2 * NUM_SETS + NUM_OPS * OP_CYCLES);

    logic                    clk_i;
    logic                    rst_ni;
    logic                    ready_o;
    logic                    dir_match_i;
    logic [SET_W-1:0]        dir_match_set_i;
    memctrl_pkg::tag_t       dir_match_tag_i;
    logic [NUM_WAYS-1:0]     dir_hit_way_o;
    logic                    dir_refill_sel_victim_i;
    logic                    dir_refill_i;
    logic [SET_W-1:0]        dir_refill_set_i;
    memctrl_pkg::tag_t       dir_refill_tag_i;
    logic [NUM_WAYS-1:0]     dir_victim_way_o;
    logic                    data_req_read_i;
    logic [SET_W-1:0]        data_req_read_set_i;
    logic [WIDX_W-1:0]       data_req_read_word_i;
    memctrl_pkg::data_word_t read_data_o;
    logic                    data_req_write_i;
    logic                    data_req_write_enable_i;
    logic [SET_W-1:0]        data_req_write_set_i;
    logic [WIDX_W-1:0]       data_req_write_word_i;
    memctrl_pkg::data_word_t data_req_write_data_i;
    logic                    data_refill_i;
    logic [NUM_WAYS-1:0]     data_refill_way_i;
    logic [SET_W-1:0]        data_refill_set_i;
    logic [WIDX_W-1:0]       data_refill_word_i;
    memctrl_pkg::data_word_t data_refill_data_i;

    // Reference model state
    logic                    mdl_valid [NUM_SETS][NUM_WAYS];
    memctrl_pkg::tag_t       mdl_tag   [NUM_SETS][NUM_WAYS];
    memctrl_pkg::data_word_t mdl_data  [NUM_SETS][NUM_WAYS][CL_WORDS];
    int                      mdl_rr;
    logic [31:0]             lcg_state;
    int                      errors;
    int                      checks;

    cache_memctrl #(
        .NUM_WAYS (NUM_WAYS),
        .NUM_SETS (NUM_SETS),
        .CL_WORDS (CL_WORDS)
    ) cache_memctrl_i (.*);

    bind cache_memctrl cache_memctrl_sva cache_memctrl_sva_i (
        .clk_i                   (clk_i),
        .rst_ni                  (rst_ni),
        .ready_o                 (ready_o),
        .dir_match_i             (dir_match_i),
        .dir_refill_sel_victim_i (dir_refill_sel_victim_i),
        .dir_refill_i            (dir_refill_i),
        .data_req_read_i         (data_req_read_i),
        .data_req_write_i        (data_req_write_i),
        .data_refill_i           (data_refill_i)
    );

    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic logic [NUM_WAYS-1:0] way_onehot(input int way);
        return NUM_WAYS'(1) << way;
    endfunction

    function automatic logic set_full(input int set);
        logic full;
        full = 1'b1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            full = full & mdl_valid[set][w];
        end
        return full;
    endfunction

    // Lowest invalid way, else the round-robin pointer
    function automatic int model_victim(input int set);
        int way;
        way = mdl_rr;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!mdl_valid[set][w]) begin
                way = w;
            end
        end
        return way;
    endfunction

    function automatic logic tag_present(input int set, input memctrl_pkg::tag_t tag);
        logic found;
        found = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            found = found | (mdl_valid[set][w] && mdl_tag[set][w] == tag);
        end
        return found;
    endfunction

    // Random tag absent from the set
    function automatic memctrl_pkg::tag_t fresh_tag(input int set);
        memctrl_pkg::tag_t tag;
        tag = memctrl_pkg::tag_t'(next_rand());
        while (tag_present(set, tag)) begin
            tag = memctrl_pkg::tag_t'(next_rand());
        end
        return tag;
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    // Lookup and read in one cycle, way -1 means a miss is expected
    task automatic lookup_and_read(input int set, input memctrl_pkg::tag_t tag,
                                   input int word, input int way);
        logic [NUM_WAYS-1:0]     exp_hit;
        memctrl_pkg::data_word_t exp_data;
        dir_match_i          = 1'b1;
        dir_match_set_i      = SET_W'(set);
        dir_match_tag_i      = tag;
        data_req_read_i      = 1'b1;
        data_req_read_set_i  = SET_W'(set);
        data_req_read_word_i = WIDX_W'(word);
        next_cycle();
        dir_match_i     = 1'b0;
        data_req_read_i = 1'b0;
        exp_hit  = '0;
        exp_data = '0;
        if (way >= 0) begin
            exp_hit  = way_onehot(way);
            exp_data = mdl_data[set][way][word];
        end
        check_equal(32'(dir_hit_way_o), 32'(exp_hit), "hit way");
        check_equal(read_data_o, exp_data, "read data");
    endtask

    // Victim read of one set, checked against the replacement rule
    task automatic select_victim(input int set);
        dir_refill_sel_victim_i = 1'b1;
        dir_refill_set_i        = SET_W'(set);
        next_cycle();
        dir_refill_sel_victim_i = 1'b0;
        check_equal(32'(dir_victim_way_o), 32'(way_onehot(model_victim(set))),
                    "victim way");
    endtask

    // Victim selection, directory refill, then the whole line into the data RAM
    task automatic refill_line(input int set, output int way, output memctrl_pkg::tag_t tag);
        memctrl_pkg::data_word_t word;
        way = model_victim(set);
        tag = fresh_tag(set);
        select_victim(set);
        dir_refill_i     = 1'b1;
        dir_refill_tag_i = tag;
        next_cycle();
        dir_refill_i = 1'b0;
        if (set_full(set)) begin
            mdl_rr = (mdl_rr + 1) % NUM_WAYS;
        end
        mdl_valid[set][way] = 1'b1;
        mdl_tag[set][way]   = tag;
        for (int i = 0; i < CL_WORDS; i++) begin
            word = {next_rand(), next_rand()};
            data_refill_i       = 1'b1;
            data_refill_way_i   = way_onehot(way);
            data_refill_set_i   = SET_W'(set);
            data_refill_word_i  = WIDX_W'(i);
            data_refill_data_i  = word;
            mdl_data[set][way][i] = word;
            next_cycle();
        end
        data_refill_i = 1'b0;
    endtask

    // Goes to the hit way of the most recent lookup
    task automatic request_write(input int set, input int way, input int word,
                                 input logic enable);
        memctrl_pkg::data_word_t data;
        data = {next_rand(), next_rand()};
        data_req_write_i        = 1'b1;
        data_req_write_enable_i = enable;
        data_req_write_set_i    = SET_W'(set);
        data_req_write_word_i   = WIDX_W'(word);
        data_req_write_data_i   = data;
        if (enable) begin
            mdl_data[set][way][word] = data;
        end
        next_cycle();
        data_req_write_i = 1'b0;
    endtask

    initial begin
        int                cycles;
        int                set;
        int                other_set;
        int                way;
        int                word;
        logic              enable;
        memctrl_pkg::tag_t tag;
        rst_ni                  = 1'b0;
        dir_match_i             = 1'b0;
        dir_match_set_i         = '0;
        dir_match_tag_i         = '0;
        dir_refill_sel_victim_i = 1'b0;
        dir_refill_i            = 1'b0;
        dir_refill_set_i        = '0;
        dir_refill_tag_i        = '0;
        data_req_read_i         = 1'b0;
        data_req_read_set_i     = '0;
        data_req_read_word_i    = '0;
        data_req_write_i        = 1'b0;
        data_req_write_enable_i = 1'b0;
        data_req_write_set_i    = '0;
        data_req_write_word_i   = '0;
        data_req_write_data_i   = '0;
        data_refill_i           = 1'b0;
        data_refill_way_i       = '0;
        data_refill_set_i       = '0;
        data_refill_word_i      = '0;
        data_refill_data_i      = '0;
        errors    = 0;
        checks    = 0;
        mdl_rr    = 0;
        lcg_state = 32'd98;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                mdl_valid[s][w] = 1'b0;
                mdl_tag[s][w]   = '0;
            end
        end

        repeat (3) @(posedge clk_i);
        #1;
        check_equal(32'(ready_o), 32'd0, "ready during reset");
        rst_ni = 1'b1;

        // Directory clear takes one cycle per set
        cycles = 0;
        while (!ready_o && cycles < 4 * NUM_SETS) begin
            next_cycle();
            cycles++;
        end
        if (!ready_o) begin
            errors++;
            $display("Error: ready_o did not rise within %0d cycles of reset", 4 * NUM_SETS);
        end else begin
            check_equal(cycles, NUM_SETS, "cycles from reset to ready");
            for (int s = 0; s < NUM_SETS; s++) begin
                lookup_and_read(s, memctrl_pkg::tag_t'(next_rand()),
                                int'(next_rand() % CL_WORDS), -1);
            end
            for (int op = 0; op < NUM_OPS; op++) begin
                set = int'(next_rand() % SETS_USED);
                refill_line(set, way, tag);
                lookup_and_read(set, tag, int'(next_rand() % CL_WORDS), way);
                // Another set's victim read moves the directory read port
                other_set = (set + 1) % SETS_USED;
                select_victim(other_set);
                word   = int'(next_rand() % CL_WORDS);
                enable = (next_rand() % 2) == 1;
                request_write(set, way, word, enable);
                lookup_and_read(set, tag, word, way);
                lookup_and_read(set, fresh_tag(set), word, -1);
            end
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not complete within %0d ns", TIMEOUT_NS);
        $display("Finished with errors");
        $finish;
    end

endmodule
